/* flist.f */
hw/hc_pkg.sv
hw/hc_csr.sv
hw/hc_requestor.sv
hw/hc_loopback.sv
hw/hc_afu.sv
verif/hc_afu_checker.sv
verif/hc_afu_props.sv
verif/hc_afu_tb.sv

/* Makefile */
# Verilator build and run of the host-copy testbench

VERILATOR ?= verilator
TOP       ?= hc_afu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verif/hc_afu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top for the host-copy function
// Clock, reset, LFSR stimulus, configuration bus driver,
// host memory with random wait states, checker and timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module hc_afu_tb;

  import hc_pkg::*;

  localparam int ADDR_W      = 16;
  localparam int DATA_W      = 32;
  localparam int FIFO_DEPTH  = 8;
  localparam int JOBS        = 12;
  localparam int MAX_LEN     = 20;
  localparam int BUSY_LEN    = 16;
  localparam int TOTAL_WORDS = JOBS * MAX_LEN + BUSY_LEN;
  localparam int CYCLE_LIMIT = 40 * TOTAL_WORDS + 2000;
  localparam logic [31:0] SEED = 32'h7342_f7d2;

  logic              clk;
  logic              reset;
  logic              cfg_cyc;
  logic              cfg_stb;
  logic              cfg_we;
  logic [2:0]        cfg_adr;
  logic [DATA_W-1:0] cfg_dat_w;
  logic [DATA_W-1:0] cfg_dat_r;
  logic              cfg_ack;
  logic              mem_cyc;
  logic              mem_stb;
  logic              mem_we;
  logic [ADDR_W-1:0] mem_adr;
  logic [DATA_W-1:0] mem_dat_w;
  logic [DATA_W-1:0] mem_dat_r = '0;
  logic              mem_ack = 1'b0;
  logic              done;
  // Source words handed to the checker as they are loaded
  logic              src_wr;
  logic [ADDR_W-1:0] src_wr_adr;
  logic [DATA_W-1:0] src_wr_dat;
  int                chk_errors;
  int                job_count;
  int                errors = 0;
  int                cycles = 0;
  logic [31:0]       stim_lfsr = SEED;
  logic [31:0]       wait_lfsr = SEED;
  logic [DATA_W-1:0] host_mem [2**ADDR_W];
  logic              pending = 1'b0;
  logic [1:0]        wait_left = '0;

  hc_afu #(
    .ADDR_W     (ADDR_W),
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) hc_afu_inst (
    .clk       (clk),
    .reset     (reset),
    .cfg_cyc   (cfg_cyc),
    .cfg_stb   (cfg_stb),
    .cfg_we    (cfg_we),
    .cfg_adr   (cfg_adr),
    .cfg_dat_w (cfg_dat_w),
    .cfg_dat_r (cfg_dat_r),
    .cfg_ack   (cfg_ack),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .mem_dat_r (mem_dat_r),
    .mem_ack   (mem_ack),
    .done      (done)
  );

  hc_afu_checker #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) checker_inst (
    .clk        (clk),
    .reset      (reset),
    .cfg_cyc    (cfg_cyc),
    .cfg_stb    (cfg_stb),
    .cfg_we     (cfg_we),
    .cfg_adr    (cfg_adr),
    .cfg_dat_w  (cfg_dat_w),
    .cfg_ack    (cfg_ack),
    .mem_cyc    (mem_cyc),
    .mem_stb    (mem_stb),
    .mem_we     (mem_we),
    .mem_adr    (mem_adr),
    .mem_dat_w  (mem_dat_w),
    .mem_ack    (mem_ack),
    .done       (done),
    .src_wr     (src_wr),
    .src_wr_adr (src_wr_adr),
    .src_wr_dat (src_wr_dat),
    .err_count  (chk_errors),
    .job_count  (job_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit that goes into the value
  task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      value = {value[30:0], state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s: expected %h, got %h", name, exp, got);
    end
  endtask

  // One configuration bus cycle, held until the slave acks
  task automatic cfg_access(input logic we, input t_hc_reg idx, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(negedge clk);
    cfg_cyc   = 1'b1;
    cfg_stb   = 1'b1;
    cfg_we    = we;
    cfg_adr   = idx;
    cfg_dat_w = wdata;
    @(negedge clk);
    while (!cfg_ack && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    if (!cfg_ack) begin
      errors++;
      $display("Configuration access to register %0d was never acknowledged", idx);
    end
    rdata   = cfg_dat_r;
    cfg_cyc = 1'b0;
    cfg_stb = 1'b0;
    cfg_we  = 1'b0;
  endtask

  task automatic cfg_write(input t_hc_reg idx, input logic [31:0] wdata);
    logic [31:0] unused;
    cfg_access(1'b1, idx, wdata, unused);
  endtask

  task automatic cfg_read(input t_hc_reg idx, output logic [31:0] rdata);
    cfg_access(1'b0, idx, '0, rdata);
  endtask

  // Source, destination and record areas sit in separate eighths of memory
  task automatic pick_bases(output logic [ADDR_W-1:0] src, output logic [ADDR_W-1:0] dst,
                            output logic [ADDR_W-1:0] dsm);
    logic [31:0] r;
    take_bits(stim_lfsr, 13, r);
    src = {3'b000, r[12:0]};
    take_bits(stim_lfsr, 13, r);
    dst = {3'b010, r[12:0]};
    take_bits(stim_lfsr, 13, r);
    dsm = {3'b100, r[12:0]};
  endtask

  task automatic load_source(input logic [ADDR_W-1:0] src, input int len);
    logic [31:0] w;
    for (int i = 0; i < len; i++) begin
      take_bits(stim_lfsr, 32, w);
      @(negedge clk);
      host_mem[src + ADDR_W'(i)] = w;
      src_wr     = 1'b1;
      src_wr_adr = src + ADDR_W'(i);
      src_wr_dat = w;
    end
    @(negedge clk);
    src_wr = 1'b0;
  endtask

  task automatic start_job(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                           input logic [ADDR_W-1:0] dsm, input logic [ADDR_W-1:0] len,
                           input t_hc_op op);
    cfg_write(REG_SRC_BASE, 32'(src));
    cfg_write(REG_DST_BASE, 32'(dst));
    cfg_write(REG_DSM_BASE, 32'(dsm));
    cfg_write(REG_LENGTH, 32'(len));
    cfg_write(REG_CONTROL, {28'h0, op, 2'b01});
  endtask

  // Waits for done, checks the status word, then clears done
  task automatic finish_job();
    logic [31:0] r;
    while (!done) begin
      @(negedge clk);
    end
    cfg_read(REG_STATUS, r);
    check_value("status", r, 32'h1 << STAT_DONE);
    cfg_write(REG_CONTROL, 32'h1 << CTRL_CLEAR_DONE);
    check_value("done", 32'(done), 32'h0);
  endtask

  // Host memory slave, 0 to 3 wait states before each ack
  always @(negedge clk) begin : host_memory
    logic [31:0] r;
    if (reset) begin
      mem_ack <= 1'b0;
      pending = 1'b0;
    end else if (mem_ack) begin
      mem_ack <= 1'b0;
    end else if (mem_cyc && mem_stb) begin
      if (!pending) begin
        take_bits(wait_lfsr, 2, r);
        wait_left = r[1:0];
        pending = 1'b1;
      end
      if (wait_left == 2'd0) begin
        pending = 1'b0;
        mem_ack <= 1'b1;
        if (mem_we) begin
          host_mem[mem_adr] = mem_dat_w;
        end else begin
          mem_dat_r <= host_mem[mem_adr];
        end
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin : stimulus
    logic [31:0]       r;
    logic [31:0]       v;
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    logic [ADDR_W-1:0] dsm;
    logic [ADDR_W-1:0] len;
    t_hc_op            op;
    int                prop_fails;
    reset      = 1'b1;
    cfg_cyc    = 1'b0;
    cfg_stb    = 1'b0;
    cfg_we     = 1'b0;
    cfg_adr    = '0;
    cfg_dat_w  = '0;
    src_wr     = 1'b0;
    src_wr_adr = '0;
    src_wr_dat = '0;
    // Every word starts with its own address in both halves
    for (int a = 0; a < 2**ADDR_W; a++) begin
      host_mem[a] = {~a[15:0], a[15:0]};
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // Idle state straight after reset
    cfg_read(REG_STATUS, r);
    check_value("status", r, 32'h0);
    check_value("done", 32'(done), 32'h0);
    check_value("mem_cyc", 32'(mem_cyc), 32'h0);

    // Address and length registers keep the low ADDR_W bits of a write
    for (int k = 2; k < 6; k++) begin
      take_bits(stim_lfsr, 32, v);
      cfg_write(t_hc_reg'(k), v);
      cfg_read(t_hc_reg'(k), r);
      check_value("cfg_dat_r", r, 32'(v[ADDR_W-1:0]));
    end
    take_bits(stim_lfsr, 2, v);
    cfg_write(REG_CONTROL, {28'h0, v[1:0], 2'b00});
    cfg_read(REG_CONTROL, r);
    check_value("cfg_dat_r", r, {28'h0, v[1:0], 2'b00});

    for (int j = 0; j < JOBS; j++) begin
      pick_bases(src, dst, dsm);
      take_bits(stim_lfsr, 5, r);
      len = ADDR_W'(r % MAX_LEN + 1);
      take_bits(stim_lfsr, 2, r);
      op = t_hc_op'(r[1:0]);
      load_source(src, int'(len));
      start_job(src, dst, dsm, len, op);
      finish_job();
    end

    // Second start with another length and transform while the first job runs
    pick_bases(src, dst, dsm);
    load_source(src, BUSY_LEN);
    start_job(src, dst, dsm, ADDR_W'(BUSY_LEN), OP_BYTE_SWAP);
    while (!mem_cyc) begin
      @(negedge clk);
    end
    cfg_read(REG_STATUS, r);
    check_value("status", r, 32'h1 << STAT_BUSY);
    cfg_write(REG_LENGTH, 32'd5);
    cfg_write(REG_CONTROL, {28'h0, OP_INVERT, 2'b01});
    finish_job();

    // Empty job writes the completion record only
    pick_bases(src, dst, dsm);
    start_job(src, dst, dsm, '0, OP_COPY);
    finish_job();

    repeat (20) @(negedge clk);
    check_value("job_count", 32'(job_count), 32'(JOBS + 2));
    prop_fails = hc_afu_inst.props_inst.fail_count;
    $display("Errors: testbench %0d, checker %0d, assertions %0d",
             errors, chk_errors, prop_fails);
    if (errors == 0 && chk_errors == 0 && prop_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : hc_afu_tb

`default_nettype wire

/* verif/hc_afu_props.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone handshake assertions bound to the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module hc_afu_props #(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 32
) (
  input logic              clk,
  input logic              reset,
  input logic              cfg_cyc,
  input logic              cfg_stb,
  input logic              cfg_ack,
  input logic              mem_cyc,
  input logic              mem_stb,
  input logic              mem_we,
  input logic [ADDR_W-1:0] mem_adr,
  input logic [DATA_W-1:0] mem_dat_w,
  input logic              mem_ack
);

  int fail_count = 0;

  // Cycle and strobe of the master rise and fall together
  assert property (@(posedge clk) disable iff (reset) mem_cyc == mem_stb)
    else begin
      fail_count++;
      $error("mem_cyc and mem_stb differ");
    end

  // A waiting request keeps all of its outputs
  assert property (@(posedge clk) disable iff (reset)
    mem_cyc && !mem_ack |=> mem_cyc && mem_stb && $stable(mem_we) &&
                            $stable(mem_adr) && $stable(mem_dat_w))
    else begin
      fail_count++;
      $error("memory request changed before its ack");
    end

  assert property (@(posedge clk) disable iff (reset) mem_cyc && mem_ack |=> !mem_cyc)
    else begin
      fail_count++;
      $error("memory request held past its ack");
    end

  // The slave acks for exactly one cycle and only for a request
  assert property (@(posedge clk) disable iff (reset) cfg_ack |=> !cfg_ack)
    else begin
      fail_count++;
      $error("cfg_ack lasted more than one cycle");
    end

  assert property (@(posedge clk) disable iff (reset) cfg_ack |-> $past(cfg_cyc && cfg_stb))
    else begin
      fail_count++;
      $error("cfg_ack without a request");
    end

endmodule : hc_afu_props

bind hc_afu hc_afu_props #(
  .ADDR_W (ADDR_W),
  .DATA_W (DATA_W)
) props_inst (
  .clk       (clk),
  .reset     (reset),
  .cfg_cyc   (cfg_cyc),
  .cfg_stb   (cfg_stb),
  .cfg_ack   (cfg_ack),
  .mem_cyc   (mem_cyc),
  .mem_stb   (mem_stb),
  .mem_we    (mem_we),
  .mem_adr   (mem_adr),
  .mem_dat_w (mem_dat_w),
  .mem_ack   (mem_ack)
);

`default_nettype wire

/* verif/hc_afu_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker for the host-copy function
// Shadows the job registers and source words, predicts every
// memory access and the completion record, counts mismatches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module hc_afu_checker #(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              cfg_cyc,
  input  logic              cfg_stb,
  input  logic              cfg_we,
  input  logic [2:0]        cfg_adr,
  input  logic [DATA_W-1:0] cfg_dat_w,
  input  logic              cfg_ack,
  input  logic              mem_cyc,
  input  logic              mem_stb,
  input  logic              mem_we,
  input  logic [ADDR_W-1:0] mem_adr,
  input  logic [DATA_W-1:0] mem_dat_w,
  input  logic              mem_ack,
  input  logic              done,
  input  logic              src_wr,
  input  logic [ADDR_W-1:0] src_wr_adr,
  input  logic [DATA_W-1:0] src_wr_dat,
  output int                err_count,
  output int                job_count
);

  import hc_pkg::*;

  logic [DATA_W-1:0] src_shadow [2**ADDR_W];
  logic [ADDR_W-1:0] src_reg;
  logic [ADDR_W-1:0] dst_reg;
  logic [ADDR_W-1:0] dsm_reg;
  logic [ADDR_W-1:0] len_reg;
  // Copy of the registers taken when a job is accepted
  logic [ADDR_W-1:0] job_src;
  logic [ADDR_W-1:0] job_dst;
  logic [ADDR_W-1:0] job_dsm;
  logic [ADDR_W-1:0] job_len;
  t_hc_op            job_op;
  logic              job_busy;
  logic              record_seen;
  logic              done_q;
  int                rd_idx;
  int                wr_idx;

  // Expected output word for one source word under a transform
  function automatic logic [DATA_W-1:0] transform(input t_hc_op op, input logic [DATA_W-1:0] w);
    logic [DATA_W-1:0] r;
    r = w;
    case (op)
      OP_INVERT:    r = ~w;
      OP_ADD_ONE:   r = w + DATA_W'(1);
      OP_BYTE_SWAP: begin
        // Lowest byte of the result is the highest byte of the source
        for (int b = 0; b < DATA_W / 8; b++) begin
          r[8*b +: 8] = w[DATA_W-1-8*b -: 8];
        end
      end
      default:      r = w;
    endcase
    return r;
  endfunction

  // Completion record, the length with the top bit set
  function automatic logic [DATA_W-1:0] record_word(input logic [ADDR_W-1:0] len);
    logic [DATA_W-1:0] r;
    r = '0;
    r[ADDR_W-1:0] = len;
    r[DATA_W-1] = 1'b1;
    return r;
  endfunction

  task automatic compare(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR %s: expected %h, got %h", name, exp, got);
    end
  endtask

  always @(posedge clk) begin : watch
    logic [ADDR_W-1:0] exp_adr;
    if (reset) begin
      err_count   = 0;
      job_count   = 0;
      job_busy    = 1'b0;
      record_seen = 1'b0;
      done_q      = 1'b0;
      rd_idx      = 0;
      wr_idx      = 0;
    end else begin
      if (src_wr) begin
        src_shadow[src_wr_adr] = src_wr_dat;
      end
      // A configuration write is taken on the edge that sees it unacknowledged
      if (cfg_cyc && cfg_stb && cfg_we && !cfg_ack) begin
        case (t_hc_reg'(cfg_adr))
          REG_SRC_BASE: src_reg = cfg_dat_w[ADDR_W-1:0];
          REG_DST_BASE: dst_reg = cfg_dat_w[ADDR_W-1:0];
          REG_DSM_BASE: dsm_reg = cfg_dat_w[ADDR_W-1:0];
          REG_LENGTH:   len_reg = cfg_dat_w[ADDR_W-1:0];
          REG_CONTROL: begin
            // A start during a running job must change nothing
            if (cfg_dat_w[CTRL_START] && !job_busy) begin
              job_src     = src_reg;
              job_dst     = dst_reg;
              job_dsm     = dsm_reg;
              job_len     = len_reg;
              job_op      = t_hc_op'(cfg_dat_w[3:2]);
              job_busy    = 1'b1;
              record_seen = 1'b0;
              rd_idx      = 0;
              wr_idx      = 0;
            end
          end
          default: ;
        endcase
      end
      if (mem_cyc && mem_stb && mem_ack) begin
        if (!job_busy) begin
          err_count++;
          $display("Memory access at address %h while no job was running", mem_adr);
        end else if (!mem_we) begin
          if (rd_idx >= int'(job_len)) begin
            err_count++;
            $display("Read at address %h goes past the end of the job", mem_adr);
          end
          exp_adr = job_src + ADDR_W'(rd_idx);
          compare("mem_adr", DATA_W'(mem_adr), DATA_W'(exp_adr));
          rd_idx++;
        end else if (wr_idx < int'(job_len)) begin
          // Data writes come in order, so a skip or a repeat shows up as a wrong address
          exp_adr = job_dst + ADDR_W'(wr_idx);
          compare("mem_adr", DATA_W'(mem_adr), DATA_W'(exp_adr));
          compare("mem_dat_w", mem_dat_w,
                  transform(job_op, src_shadow[job_src + ADDR_W'(wr_idx)]));
          wr_idx++;
        end else begin
          // Every data write is done, so this one has to be the completion record
          compare("mem_adr", DATA_W'(mem_adr), DATA_W'(job_dsm));
          compare("mem_dat_w", mem_dat_w, record_word(job_len));
          job_busy    = 1'b0;
          record_seen = 1'b1;
          job_count++;
        end
      end
      if (done && !done_q) begin
        if (!record_seen) begin
          err_count++;
          $display("done rose without a completion record before it");
        end
        record_seen = 1'b0;
      end
      done_q = done;
    end
  end

endmodule : hc_afu_checker

`default_nettype wire

/* hw/hc_afu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the host-copy function
// Configuration block, memory requestor and loopback core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module hc_afu #(
  parameter int ADDR_W     = 16,
  parameter int DATA_W     = 32,
  parameter int FIFO_DEPTH = 8
) (
  input  logic              clk,
  input  logic              reset,
  // Configuration port, Wishbone classic slave
  input  logic              cfg_cyc,
  input  logic              cfg_stb,
  input  logic              cfg_we,
  input  logic [2:0]        cfg_adr,
  input  logic [DATA_W-1:0] cfg_dat_w,
  output logic [DATA_W-1:0] cfg_dat_r,
  output logic              cfg_ack,
  // Host memory port, Wishbone classic master
  output logic              mem_cyc,
  output logic              mem_stb,
  output logic              mem_we,
  output logic [ADDR_W-1:0] mem_adr,
  output logic [DATA_W-1:0] mem_dat_w,
  input  logic [DATA_W-1:0] mem_dat_r,
  input  logic              mem_ack,
  output logic              done
);

  import hc_pkg::*;

  logic              start;
  logic              finish;
  logic              busy;
  logic [ADDR_W-1:0] src_base;
  logic [ADDR_W-1:0] dst_base;
  logic [ADDR_W-1:0] dsm_base;
  logic [ADDR_W-1:0] length;
  t_hc_op            op;
  logic              push;
  logic              pop;
  logic              full;
  logic              empty;
  logic [DATA_W-1:0] push_data;
  logic [DATA_W-1:0] pop_data;

  hc_csr #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) uu_hc_csr (
    .clk       (clk),
    .reset     (reset),
    .cfg_cyc   (cfg_cyc),
    .cfg_stb   (cfg_stb),
    .cfg_we    (cfg_we),
    .cfg_adr   (cfg_adr),
    .cfg_dat_w (cfg_dat_w),
    .cfg_dat_r (cfg_dat_r),
    .cfg_ack   (cfg_ack),
    .busy      (busy),
    .finish    (finish),
    .start     (start),
    .src_base  (src_base),
    .dst_base  (dst_base),
    .dsm_base  (dsm_base),
    .length    (length),
    .op        (op),
    .done      (done)
  );

  hc_requestor #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) uu_hc_requestor (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .src_base  (src_base),
    .dst_base  (dst_base),
    .dsm_base  (dsm_base),
    .length    (length),
    .busy      (busy),
    .finish    (finish),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .mem_dat_r (mem_dat_r),
    .mem_ack   (mem_ack),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty)
  );

  // Words in flight sit here between the read and write phases
  hc_loopback #(
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uu_hc_loopback (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .op        (op),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty)
  );

endmodule : hc_afu

`default_nettype wire

/* hw/hc_loopback.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Loopback core holding the words of a job in flight
// Circular word FIFO with the job transform on its head
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module hc_loopback #(
  parameter int DATA_W     = 32,
  parameter int FIFO_DEPTH = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              push,
  input  logic [DATA_W-1:0] push_data,
  input  logic              pop,
  input  hc_pkg::t_hc_op    op,
  output logic [DATA_W-1:0] pop_data,
  output logic              full,
  output logic              empty
);

  import hc_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

  logic [DATA_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic [DATA_W-1:0] head;
  logic [DATA_W-1:0] swapped;
  logic              do_push;
  logic              do_pop;

  assign full    = (count == FULL_COUNT);
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];

  // Storage itself has no reset, only the pointers do
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own since the depth is a power of two
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Byte 0 swaps with the top byte and so on inward
  always_comb begin
    for (int i = 0; i < DATA_W / 8; i++) begin
      swapped[8*i +: 8] = head[DATA_W-8-8*i +: 8];
    end
  end

  always_comb begin
    case (op)
      OP_COPY:      pop_data = head;
      OP_INVERT:    pop_data = ~head;
      OP_BYTE_SWAP: pop_data = swapped;
      OP_ADD_ONE:   pop_data = head + 1'b1;
      default:      pop_data = head;
    endcase
  end

endmodule : hc_loopback

`default_nettype wire

/* hw/hc_requestor.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory requestor on a Wishbone classic master
// Alternates read and write phases through the loopback FIFO
// and ends each job with a completion record write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module hc_requestor #(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic [ADDR_W-1:0] src_base,
  input  logic [ADDR_W-1:0] dst_base,
  input  logic [ADDR_W-1:0] dsm_base,
  input  logic [ADDR_W-1:0] length,
  output logic              busy,
  output logic              finish,
  output logic              mem_cyc,
  output logic              mem_stb,
  output logic              mem_we,
  output logic [ADDR_W-1:0] mem_adr,
  output logic [DATA_W-1:0] mem_dat_w,
  input  logic [DATA_W-1:0] mem_dat_r,
  input  logic              mem_ack,
  output logic              push,
  output logic [DATA_W-1:0] push_data,
  input  logic              full,
  output logic              pop,
  input  logic [DATA_W-1:0] pop_data,
  input  logic              empty
);

  import hc_pkg::*;

  localparam int VALID_BIT = dsm_valid_bit(DATA_W);

  t_req_state        state;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [ADDR_W-1:0] dsm_q;
  logic [ADDR_W-1:0] len_q;
  logic [ADDR_W-1:0] rd_cnt;
  logic [ADDR_W-1:0] wr_cnt;
  logic [DATA_W-1:0] dsm_word;
  logic              acked;

  assign busy  = (state != ST_IDLE);
  assign acked = mem_cyc && mem_ack;

  // Read data enters the FIFO on the read ack
  assign push      = (state == ST_READ) && acked;
  assign push_data = mem_dat_r;

  // The FIFO head leaves only once its write is acknowledged
  assign pop = (state == ST_WRITE) && acked;

  // Completion record is the job length with the valid bit on top
  always_comb begin
    dsm_word              = '0;
    dsm_word[ADDR_W-1:0]  = len_q;
    dsm_word[VALID_BIT]   = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      src_q     <= '0;
      dst_q     <= '0;
      dsm_q     <= '0;
      len_q     <= '0;
      rd_cnt    <= '0;
      wr_cnt    <= '0;
      finish    <= 1'b0;
      mem_cyc   <= 1'b0;
      mem_stb   <= 1'b0;
      mem_we    <= 1'b0;
      mem_adr   <= '0;
      mem_dat_w <= '0;
    end else begin
      finish <= 1'b0;
      // Every request drops in the cycle after its ack
      if (acked) begin
        mem_cyc <= 1'b0;
        mem_stb <= 1'b0;
      end
      case (state)
        ST_IDLE: begin
          // Job registers are captured so later writes cannot disturb the job
          if (start) begin
            src_q  <= src_base;
            dst_q  <= dst_base;
            dsm_q  <= dsm_base;
            len_q  <= length;
            rd_cnt <= '0;
            wr_cnt <= '0;
            state  <= ST_READ;
          end
        end
        ST_READ: begin
          if (acked) begin
            rd_cnt <= rd_cnt + 1'b1;
          end else if (!mem_cyc) begin
            // Fill the FIFO until it is full or the source is exhausted
            if (rd_cnt != len_q && !full) begin
              mem_cyc <= 1'b1;
              mem_stb <= 1'b1;
              mem_we  <= 1'b0;
              mem_adr <= src_q + rd_cnt;
            end else begin
              state <= ST_WRITE;
            end
          end
        end
        ST_WRITE: begin
          if (acked) begin
            wr_cnt <= wr_cnt + 1'b1;
          end else if (!mem_cyc) begin
            if (!empty) begin
              mem_cyc   <= 1'b1;
              mem_stb   <= 1'b1;
              mem_we    <= 1'b1;
              mem_adr   <= dst_q + wr_cnt;
              mem_dat_w <= pop_data;
            end else if (wr_cnt == len_q) begin
              state <= ST_DSM;
            end else begin
              // Drained but words remain, so refill
              state <= ST_READ;
            end
          end
        end
        ST_DSM: begin
          if (acked) begin
            finish <= 1'b1;
            state  <= ST_IDLE;
          end else if (!mem_cyc) begin
            mem_cyc   <= 1'b1;
            mem_stb   <= 1'b1;
            mem_we    <= 1'b1;
            mem_adr   <= dsm_q;
            mem_dat_w <= dsm_word;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule : hc_requestor

`default_nettype wire

/* hw/hc_csr.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration register block on a Wishbone classic slave
// Holds the job registers, issues the start pulse and keeps done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module hc_csr #(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              cfg_cyc,
  input  logic              cfg_stb,
  input  logic              cfg_we,
  input  logic [2:0]        cfg_adr,
  input  logic [DATA_W-1:0] cfg_dat_w,
  output logic [DATA_W-1:0] cfg_dat_r,
  output logic              cfg_ack,
  input  logic              busy,
  input  logic              finish,
  output logic              start,
  output logic [ADDR_W-1:0] src_base,
  output logic [ADDR_W-1:0] dst_base,
  output logic [ADDR_W-1:0] dsm_base,
  output logic [ADDR_W-1:0] length,
  output hc_pkg::t_hc_op    op,
  output logic              done
);

  import hc_pkg::*;

  t_hc_reg           reg_idx;
  logic              req;
  logic [DATA_W-1:0] rd_data;

  // The bus index maps straight onto the register enum
  assign reg_idx = t_hc_reg'(cfg_adr);

  // A new request is one that has not been acknowledged yet
  assign req = cfg_cyc && cfg_stb && !cfg_ack;

  // Read mux that is sampled into cfg_dat_r together with the ack
  always_comb begin
    rd_data = '0;
    case (reg_idx)
      REG_CONTROL:  rd_data[3:2] = op;
      REG_STATUS: begin
        rd_data[STAT_BUSY] = busy;
        rd_data[STAT_DONE] = done;
      end
      REG_SRC_BASE: rd_data[ADDR_W-1:0] = src_base;
      REG_DST_BASE: rd_data[ADDR_W-1:0] = dst_base;
      REG_LENGTH:   rd_data[ADDR_W-1:0] = length;
      REG_DSM_BASE: rd_data[ADDR_W-1:0] = dsm_base;
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_ack   <= 1'b0;
      cfg_dat_r <= '0;
      start     <= 1'b0;
      src_base  <= '0;
      dst_base  <= '0;
      dsm_base  <= '0;
      length    <= '0;
      op        <= OP_COPY;
      done      <= 1'b0;
    end else begin
      // Ack follows the request by one cycle and lasts one cycle
      cfg_ack <= req;
      start   <= 1'b0;
      if (req) begin
        cfg_dat_r <= rd_data;
      end
      if (req && cfg_we) begin
        case (reg_idx)
          REG_CONTROL: begin
            // A running job keeps its transform and never sees a second start
            if (!busy) begin
              op    <= t_hc_op'(cfg_dat_w[3:2]);
              // Start leaves together with the ack
              start <= cfg_dat_w[CTRL_START];
            end
            if (cfg_dat_w[CTRL_CLEAR_DONE] || (cfg_dat_w[CTRL_START] && !busy)) begin
              done <= 1'b0;
            end
          end
          REG_SRC_BASE: src_base <= cfg_dat_w[ADDR_W-1:0];
          REG_DST_BASE: dst_base <= cfg_dat_w[ADDR_W-1:0];
          REG_LENGTH:   length   <= cfg_dat_w[ADDR_W-1:0];
          REG_DSM_BASE: dsm_base <= cfg_dat_w[ADDR_W-1:0];
          // Status is read only
          default: ;
        endcase
      end
      // Job completion wins over a clear in the same cycle
      if (finish) begin
        done <= 1'b1;
      end
    end
  end

endmodule : hc_csr

`default_nettype wire

/* hw/hc_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions of the host-copy function
// Register word indices, transform opcodes, requestor states,
// control and status bit positions and the completion valid bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package hc_pkg;

  // Word index on the configuration bus
  typedef enum logic [2:0] {
    REG_CONTROL  = 3'd0,
    REG_STATUS   = 3'd1,
    REG_SRC_BASE = 3'd2,
    REG_DST_BASE = 3'd3,
    REG_LENGTH   = 3'd4,
    REG_DSM_BASE = 3'd5
  } t_hc_reg;

  // Transform applied to each word, carried in control bits 3:2
  typedef enum logic [1:0] {
    OP_COPY      = 2'd0,
    OP_INVERT    = 2'd1,
    OP_BYTE_SWAP = 2'd2,
    OP_ADD_ONE   = 2'd3
  } t_hc_op;

  // Job phases of the memory requestor
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_READ  = 2'd1,
    ST_WRITE = 2'd2,
    ST_DSM   = 2'd3
  } t_req_state;

  // Control register bits, both act as one-shot commands
  localparam int CTRL_START      = 0;
  localparam int CTRL_CLEAR_DONE = 1;

  // Status register bits
  localparam int STAT_BUSY = 0;
  localparam int STAT_DONE = 1;

  // The completion record is marked valid by its top bit
  function automatic int dsm_valid_bit(input int data_w);
    return data_w - 1;
  endfunction

endpackage : hc_pkg

`default_nettype wire
